// File: tb.f
+incdir+include
logic/isa_pkg.sv
logic/issue_pkg.sv
logic/rs_entry_array.sv
logic/issue_control.sv
logic/issue_packet_former.sv
logic/issue_stage_top.sv
tests/issue_stage_tb.sv

// File: Bender.yml
package:
  name: issue_stage

sources:
  - include_dirs:
      - include
    files:
      - logic/isa_pkg.sv
      - logic/issue_pkg.sv
      - logic/rs_entry_array.sv
      - logic/issue_control.sv
      - logic/issue_packet_former.sv
      - logic/issue_stage_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/issue_stage_tb.sv

// File: tests/issue_stage_tb.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_stage_tb;

    localparam int NEVER = 32'h4000_0000;

    logic                     clock;
    logic                     rst_n_i;
    logic                     disp_valid_i;
    issue_pkg::disp_packet_t  disp_packet_i;
    issue_pkg::cdb_t          cdb_i;
    issue_pkg::fu_vec_t       credit_return_i;
    logic                     rs_full_o;
    issue_pkg::issue_packet_t alu_req_o;
    issue_pkg::issue_packet_t mul_req_o;
    issue_pkg::issue_packet_t load_req_o;
    issue_pkg::issue_packet_t br_req_o;

    // ====================
    // scoreboard state
    // ====================
    // keyed by rob index
    issue_pkg::disp_packet_t sb_pkt [`ROB_DEPTH];
    bit  rob_busy [`ROB_DEPTH];
    bit  rob_taken [`ROB_DEPTH];
    int  acc_neg [`ROB_DEPTH];
    int  elig_neg [`ROB_DEPTH];
    int  pending_ret [`FU_NUM];
    int  next_due [`FU_NUM];
    int  phase_issued [`FU_NUM];
    int  neg_cnt;
    int  occ;
    bit  lat_check;
    bit  hold_returns;
    // next inputs for tick to drive
    bit                      offer_valid;
    issue_pkg::disp_packet_t offer_pkt;
    bit                      cdb_valid;
    issue_pkg::tag_t         cdb_tag;

    issue_stage_top issue_stage_top_inst (
        .clock           (clock),
        .rst_n_i         (rst_n_i),
        .disp_valid_i    (disp_valid_i),
        .disp_packet_i   (disp_packet_i),
        .cdb_i           (cdb_i),
        .credit_return_i (credit_return_i),
        .rs_full_o       (rs_full_o),
        .alu_req_o       (alu_req_o),
        .mul_req_o       (mul_req_o),
        .load_req_o      (load_req_o),
        .br_req_o        (br_req_o)
    );

    always #5 clock = ~clock;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout while waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    endtask

    // ====================
    // reference operand rules
    // ====================
    function automatic logic [31:0] ref_imm(input logic [2:0] sel, input logic [31:0] x);
        case (sel)
            3'd1:    return {{20{x[31]}}, x[31:20]};
            3'd2:    return {{20{x[31]}}, x[31:25], x[11:7]};
            3'd3:    return {{19{x[31]}}, x[31], x[7], x[30:25], x[11:8], 1'b0};
            3'd4:    return {x[31:12], 12'b0};
            default: return {{11{x[31]}}, x[31], x[19:12], x[20], x[30:21], 1'b0};
        endcase
    endfunction

    function automatic logic [31:0] ref_src1(input issue_pkg::disp_packet_t d);
        case (d.opa_select)
            isa_pkg::OPA_IS_RS1: return 32'(d.src1_tag);
            isa_pkg::OPA_IS_NPC: return d.npc;
            isa_pkg::OPA_IS_PC:  return d.pc;
            default:             return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] ref_src2(input issue_pkg::disp_packet_t d);
        // register source travels as its tag
        if (d.opb_select == isa_pkg::OPB_IS_RS2) begin
            return 32'(d.src2_tag);
        end
        return ref_imm(d.opb_select, d.inst);
    endfunction

    // ====================
    // port observation
    // ====================
    task automatic observe_port(input int c, input issue_pkg::issue_packet_t p);
        int                      r;
        issue_pkg::disp_packet_t d;
        if (p.valid) begin
            r = int'(p.rob_idx);
            check_value("issued rob index in flight", 1, rob_busy[r]);
            d = sb_pkt[r];
            check_value("port class", 32'(d.fu_type), c);
            check_value("packet fu type", c, 32'(p.fu_type));
            check_value("opcode", 32'(d.alu_func), 32'(p.opcode));
            check_value("src1_val", ref_src1(d), p.src1_val);
            check_value("src2_val", ref_src2(d), p.src2_val);
            check_value("imm", ref_src2(d), p.imm);
            // only I and U immediates stand in for src2
            check_value("src2_valid",
                        !(d.opb_select inside {isa_pkg::OPB_IS_I_IMM, isa_pkg::OPB_IS_U_IMM}),
                        p.src2_valid);
            check_value("dest tag", 32'(d.dest_tag), 32'(p.dest_tag));
            check_value("sources ready at issue", 1, d.src1_ready && d.src2_ready);
            check_value("issue not before wakeup", 1, neg_cnt >= elig_neg[r] + 2);
            if (lat_check) begin
                check_value("minimum latency", acc_neg[r] + 2, neg_cnt);
            end
            rob_busy[r]  = 0;
            rob_taken[r] = 0;
            occ--;
            if (pending_ret[c] == 0) begin
                next_due[c] = neg_cnt + $urandom_range(1, 4);
            end
            pending_ret[c]++;
            check_value("credit bound", 1, pending_ret[c] <= 2);
            phase_issued[c]++;
        end
    endtask

    // observe on the falling edge then drive
    task automatic tick();
        bit accepted;
        @(negedge clock);
        neg_cnt++;
        observe_port(isa_pkg::FU_ALU, alu_req_o);
        observe_port(isa_pkg::FU_MUL, mul_req_o);
        observe_port(isa_pkg::FU_LOAD, load_req_o);
        observe_port(isa_pkg::FU_BRANCH, br_req_o);
        check_value("full flag", occ == `RS_DEPTH, rs_full_o);
        // dispatch held until taken
        disp_valid_i  = offer_valid;
        disp_packet_i = offer_pkt;
        accepted = offer_valid && !rs_full_o;
        if (accepted) begin
            sb_pkt[offer_pkt.rob_idx]   = offer_pkt;
            rob_busy[offer_pkt.rob_idx] = 1;
            acc_neg[offer_pkt.rob_idx]  = neg_cnt;
            elig_neg[offer_pkt.rob_idx] = NEVER;
            if (offer_pkt.src1_ready && offer_pkt.src2_ready) begin
                elig_neg[offer_pkt.rob_idx] = neg_cnt;
            end
            occ++;
            offer_valid = 0;
        end
        // cdb also hits the packet taken at this edge
        cdb_i.valid = cdb_valid;
        cdb_i.tag   = cdb_tag;
        if (cdb_valid) begin
            for (int r = 0; r < `ROB_DEPTH; r++) begin
                if (rob_busy[r]) begin
                    if (sb_pkt[r].src1_tag == cdb_tag) begin
                        sb_pkt[r].src1_ready = 1;
                    end
                    if (sb_pkt[r].src2_tag == cdb_tag) begin
                        sb_pkt[r].src2_ready = 1;
                    end
                    if (sb_pkt[r].src1_ready && sb_pkt[r].src2_ready &&
                        elig_neg[r] == NEVER) begin
                        elig_neg[r] = neg_cnt;
                    end
                end
            end
        end
        cdb_valid = 0;
        // at most one credit return per class per cycle
        for (int c = 0; c < `FU_NUM; c++) begin
            credit_return_i[c] = 1'b0;
            if (!hold_returns && pending_ret[c] > 0 && next_due[c] <= neg_cnt) begin
                credit_return_i[c] = 1'b1;
                pending_ret[c]--;
                next_due[c] = neg_cnt + $urandom_range(1, 4);
            end
        end
    endtask

    // random micro-op with a free rob index
    task automatic new_op(input int fu, input int ready_pct);
        issue_pkg::disp_packet_t d;
        int                      r;
        int                      start;
        r = -1;
        start = $urandom_range(0, `ROB_DEPTH - 1);
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            if (r < 0 && !rob_taken[(start + k) % `ROB_DEPTH]) begin
                r = (start + k) % `ROB_DEPTH;
            end
        end
        if (r >= 0) begin
            d = '0;
            d.inst       = $urandom;
            d.pc         = $urandom;
            d.npc        = d.pc + 32'd4;
            d.opa_select = isa_pkg::opa_sel_e'($urandom_range(0, 3));
            d.opb_select = isa_pkg::opb_sel_e'($urandom_range(0, 5));
            d.alu_func   = isa_pkg::alu_func_e'($urandom_range(0, 13));
            d.fu_type    = isa_pkg::fu_type_e'(fu);
            d.rob_idx    = issue_pkg::rob_idx_t'(r);
            d.dest_tag   = issue_pkg::tag_t'($urandom);
            // waiting sources use tags 48..63 and ready ones lower
            d.src1_ready = $urandom_range(0, 99) < ready_pct;
            d.src2_ready = $urandom_range(0, 99) < ready_pct;
            d.src1_tag   = d.src1_ready ? $urandom_range(0, 47) : $urandom_range(48, 63);
            d.src2_tag   = d.src2_ready ? $urandom_range(0, 47) : $urandom_range(48, 63);
            rob_taken[r] = 1;
            offer_pkt    = d;
            offer_valid  = 1;
        end
    endtask

    task automatic wait_taken();
        int t;
        t = 0;
        while (offer_valid) begin
            tick();
            t++;
            if (t > 50) begin
                timed_out("dispatch to be accepted");
            end
        end
    endtask

    // every op issued and every credit back
    task automatic wait_drain(input int limit);
        int  t;
        bit  busy;
        t = 0;
        busy = 1;
        while (busy) begin
            busy = offer_valid;
            for (int r = 0; r < `ROB_DEPTH; r++) begin
                busy = busy || rob_taken[r];
            end
            for (int c = 0; c < `FU_NUM; c++) begin
                busy = busy || pending_ret[c] > 0;
            end
            if (busy) begin
                cdb_valid = 1;
                cdb_tag   = issue_pkg::tag_t'(48 + t % 16);
                tick();
                t++;
                if (t > limit) begin
                    timed_out("all dispatched ops to issue and credits to return");
                end
            end
        end
    endtask

    initial begin
        int t;
        int r;
        void'($urandom(32'h4532));
        clock           = 1'b0;
        rst_n_i         = 1'b0;
        disp_valid_i    = 1'b0;
        disp_packet_i   = '0;
        cdb_i           = '0;
        credit_return_i = '0;
        neg_cnt = 0;
        occ = 0;
        lat_check = 0;
        hold_returns = 0;
        offer_valid = 0;
        offer_pkt = '0;
        cdb_valid = 0;
        cdb_tag = '0;
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            rob_busy[i]  = 0;
            rob_taken[i] = 0;
        end
        for (int c = 0; c < `FU_NUM; c++) begin
            pending_ret[c]  = 0;
            next_due[c]     = 0;
            phase_issued[c] = 0;
        end
        repeat (10) @(negedge clock);
        rst_n_i = 1'b1;

        // ====================
        // reset state
        // ====================
        check_value("reset alu valid", 0, alu_req_o.valid);
        check_value("reset mul valid", 0, mul_req_o.valid);
        check_value("reset load valid", 0, load_req_o.valid);
        check_value("reset br valid", 0, br_req_o.valid);
        check_value("reset full", 0, rs_full_o);

        // empty station with full credits takes two edges
        lat_check = 1;
        for (int c = 0; c < `FU_NUM; c++) begin
            new_op(c, 100);
            r = offer_pkt.rob_idx;
            tick();
            t = 0;
            while (rob_busy[r]) begin
                tick();
                t++;
                if (t > 20) begin
                    timed_out("single op to issue");
                end
            end
        end
        lat_check = 0;
        wait_drain(100);

        // ====================
        // credits withheld
        // ====================
        hold_returns = 1;
        for (int c = 0; c < `FU_NUM; c++) begin
            phase_issued[c] = 0;
        end
        repeat (3) begin
            new_op(isa_pkg::FU_ALU, 100);
            wait_taken();
        end
        t = 0;
        while (phase_issued[isa_pkg::FU_ALU] < 2) begin
            tick();
            t++;
            if (t > 50) begin
                timed_out("alu to use its credits");
            end
        end
        repeat (10) tick();
        check_value("alu stops at credit limit", 2, phase_issued[isa_pkg::FU_ALU]);
        // third alu op still waits in the station
        repeat (2) begin
            new_op(isa_pkg::FU_MUL, 100);
            wait_taken();
        end
        t = 0;
        while (phase_issued[isa_pkg::FU_MUL] < 2) begin
            tick();
            t++;
            if (t > 50) begin
                timed_out("mul to issue beside the stalled alu");
            end
        end
        hold_returns = 0;
        wait_drain(200);

        // ====================
        // random traffic
        // ====================
        repeat (600) begin
            if (!offer_valid && $urandom_range(0, 2) != 0) begin
                new_op($urandom_range(0, 3), 60);
            end
            if ($urandom_range(0, 3) == 0) begin
                cdb_valid = 1;
                cdb_tag   = issue_pkg::tag_t'($urandom_range(48, 63));
            end
            tick();
        end
        wait_drain(600);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: logic/issue_stage_top.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_stage_top (
    input  logic                     clock,
    input  logic                     rst_n_i,
    input  logic                     disp_valid_i,
    input  issue_pkg::disp_packet_t  disp_packet_i,
    input  issue_pkg::cdb_t          cdb_i,
    input  issue_pkg::fu_vec_t       credit_return_i,
    output logic                     rs_full_o,
    output issue_pkg::issue_packet_t alu_req_o,
    output issue_pkg::issue_packet_t mul_req_o,
    output issue_pkg::issue_packet_t load_req_o,
    output issue_pkg::issue_packet_t br_req_o
);

    // storage to control and former
    issue_pkg::rs_entry_t [`RS_DEPTH-1:0] entries;
    logic [`RS_DEPTH-1:0]                 valid_mask;
    logic [`RS_DEPTH-1:0]                 ready_mask;

    // control to storage
    logic                                 alloc_en;
    issue_pkg::rs_idx_t                   alloc_idx;
    logic [`RS_DEPTH-1:0]                 clear_mask;

    // control to former
    issue_pkg::fu_vec_t                   grant;
    issue_pkg::rs_idx_t [`FU_NUM-1:0]     grant_idx;

    rs_entry_array rs_entry_array_inst (
        .clock         (clock),
        .rst_n_i       (rst_n_i),
        .alloc_en_i    (alloc_en),
        .alloc_idx_i   (alloc_idx),
        .disp_packet_i (disp_packet_i),
        .cdb_i         (cdb_i),
        .clear_mask_i  (clear_mask),
        .entries_o     (entries),
        .valid_mask_o  (valid_mask),
        .ready_mask_o  (ready_mask)
    );

    issue_control issue_control_inst (
        .clock           (clock),
        .rst_n_i         (rst_n_i),
        .disp_valid_i    (disp_valid_i),
        .valid_mask_i    (valid_mask),
        .ready_mask_i    (ready_mask),
        .entries_i       (entries),
        .credit_return_i (credit_return_i),
        .rs_full_o       (rs_full_o),
        .alloc_en_o      (alloc_en),
        .alloc_idx_o     (alloc_idx),
        .grant_o         (grant),
        .grant_idx_o     (grant_idx),
        .clear_mask_o    (clear_mask)
    );

    issue_packet_former issue_packet_former_inst (
        .clock       (clock),
        .rst_n_i     (rst_n_i),
        .entries_i   (entries),
        .grant_i     (grant),
        .grant_idx_i (grant_idx),
        .alu_req_o   (alu_req_o),
        .mul_req_o   (mul_req_o),
        .load_req_o  (load_req_o),
        .br_req_o    (br_req_o)
    );

endmodule

// File: logic/issue_packet_former.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_packet_former (
    input  logic                                    clock,
    input  logic                                    rst_n_i,
    input  issue_pkg::rs_entry_t [`RS_DEPTH-1:0]    entries_i,
    input  issue_pkg::fu_vec_t                      grant_i,
    input  issue_pkg::rs_idx_t [`FU_NUM-1:0]        grant_idx_i,
    output issue_pkg::issue_packet_t                alu_req_o,
    output issue_pkg::issue_packet_t                mul_req_o,
    output issue_pkg::issue_packet_t                load_req_o,
    output issue_pkg::issue_packet_t                br_req_o
);

    issue_pkg::issue_packet_t formed [`FU_NUM];
    issue_pkg::issue_packet_t pkt_q [`FU_NUM];
    issue_pkg::fu_vec_t       valid_q;

    // operand muxing for one entry
    function automatic issue_pkg::issue_packet_t form_packet(
        input issue_pkg::disp_packet_t d
    );
        issue_pkg::issue_packet_t p;
        logic [`XLEN-1:0]         opb;
        p = '0;
        case (d.opa_select)
            isa_pkg::OPA_IS_RS1: p.src1_val = `XLEN'(d.src1_tag);
            isa_pkg::OPA_IS_NPC: p.src1_val = d.npc;
            isa_pkg::OPA_IS_PC:  p.src1_val = d.pc;
            default:             p.src1_val = '0;
        endcase
        case (d.opb_select)
            isa_pkg::OPB_IS_RS2:   opb = `XLEN'(d.src2_tag);
            isa_pkg::OPB_IS_I_IMM: opb = isa_pkg::imm_i(d.inst);
            isa_pkg::OPB_IS_S_IMM: opb = isa_pkg::imm_s(d.inst);
            isa_pkg::OPB_IS_B_IMM: opb = isa_pkg::imm_b(d.inst);
            isa_pkg::OPB_IS_U_IMM: opb = isa_pkg::imm_u(d.inst);
            isa_pkg::OPB_IS_J_IMM: opb = isa_pkg::imm_j(d.inst);
            default:               opb = '0;
        endcase
        p.valid      = 1'b1;
        p.opcode     = d.alu_func;
        p.src2_val   = opb;
        p.imm        = opb;
        // I and U immediates replace the second source
        p.src2_valid = !(d.opb_select == isa_pkg::OPB_IS_I_IMM ||
                         d.opb_select == isa_pkg::OPB_IS_U_IMM);
        p.rob_idx    = d.rob_idx;
        p.dest_tag   = d.dest_tag;
        p.fu_type    = d.fu_type;
        return p;
    endfunction

    // one packet per class from its granted entry
    always_comb begin
        for (int c = 0; c < `FU_NUM; c++) begin
            formed[c] = form_packet(entries_i[grant_idx_i[c]].disp_packet);
        end
    end

    // ====================
    // unit port registers
    // ====================
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= grant_i;
        end
    end

    // payload only moves on a grant
    always_ff @(posedge clock) begin
        for (int c = 0; c < `FU_NUM; c++) begin
            if (grant_i[c]) begin
                pkt_q[c] <= formed[c];
            end
        end
    end

    // valid for one cycle, unit must take it
    always_comb begin
        alu_req_o        = pkt_q[isa_pkg::FU_ALU];
        alu_req_o.valid  = valid_q[isa_pkg::FU_ALU];
        mul_req_o        = pkt_q[isa_pkg::FU_MUL];
        mul_req_o.valid  = valid_q[isa_pkg::FU_MUL];
        load_req_o       = pkt_q[isa_pkg::FU_LOAD];
        load_req_o.valid = valid_q[isa_pkg::FU_LOAD];
        br_req_o         = pkt_q[isa_pkg::FU_BRANCH];
        br_req_o.valid   = valid_q[isa_pkg::FU_BRANCH];
    end

endmodule

// File: logic/issue_control.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module issue_control (
    input  logic                                    clock,
    input  logic                                    rst_n_i,
    input  logic                                    disp_valid_i,
    input  logic [`RS_DEPTH-1:0]                    valid_mask_i,
    input  logic [`RS_DEPTH-1:0]                    ready_mask_i,
    input  issue_pkg::rs_entry_t [`RS_DEPTH-1:0]    entries_i,
    input  issue_pkg::fu_vec_t                      credit_return_i,
    output logic                                    rs_full_o,
    output logic                                    alloc_en_o,
    output issue_pkg::rs_idx_t                      alloc_idx_o,
    output issue_pkg::fu_vec_t                      grant_o,
    output issue_pkg::rs_idx_t [`FU_NUM-1:0]        grant_idx_o,
    output logic [`RS_DEPTH-1:0]                    clear_mask_o
);

    // reset value per class, in fu_type_e order
    localparam logic [`CREDIT_W-1:0] INIT_CREDITS [`FU_NUM] = '{
        `CREDIT_W'(`ALU_CREDITS),
        `CREDIT_W'(`MUL_CREDITS),
        `CREDIT_W'(`LOAD_CREDITS),
        `CREDIT_W'(`BR_CREDITS)
    };

    logic                  rs_full_q;
    logic [`CREDIT_W-1:0]  credit_q [`FU_NUM];
    logic [`RS_DEPTH-1:0]  alloc_onehot;
    logic [`RS_DEPTH-1:0]  next_valid;
    logic [`RS_DEPTH-1:0]  class_cand [`FU_NUM];

    // lowest set bit, shared by allocation and grant select
    function automatic issue_pkg::rs_idx_t lowest_set(input logic [`RS_DEPTH-1:0] vec);
        issue_pkg::rs_idx_t idx;
        idx = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = issue_pkg::rs_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // ====================
    // allocation
    // ====================
    assign alloc_en_o  = disp_valid_i && !rs_full_q;
    assign alloc_idx_o = lowest_set(~valid_mask_i);

    always_comb begin
        alloc_onehot = '0;
        if (alloc_en_o) begin
            alloc_onehot[alloc_idx_o] = 1'b1;
        end
    end

    // occupancy after this edge
    assign next_valid = (valid_mask_i | alloc_onehot) & ~clear_mask_o;

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            rs_full_q <= 1'b0;
        end else begin
            rs_full_q <= &next_valid;
        end
    end

    assign rs_full_o = rs_full_q;

    // ====================
    // grant select
    // ====================
    always_comb begin
        grant_o      = '0;
        grant_idx_o  = '0;
        clear_mask_o = '0;
        for (int c = 0; c < `FU_NUM; c++) begin
            // ready entries of this class, nothing if out of credit
            for (int i = 0; i < `RS_DEPTH; i++) begin
                class_cand[c][i] = ready_mask_i[i] && credit_q[c] != '0 &&
                    entries_i[i].disp_packet.fu_type == isa_pkg::fu_type_e'(c);
            end
            grant_o[c]     = |class_cand[c];
            grant_idx_o[c] = lowest_set(class_cand[c]);
            if (grant_o[c]) begin
                clear_mask_o[grant_idx_o[c]] = 1'b1;
            end
        end
    end

    // ====================
    // credit counters
    // ====================
    // grant and return together leave the count as is
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int c = 0; c < `FU_NUM; c++) begin
                credit_q[c] <= INIT_CREDITS[c];
            end
        end else begin
            for (int c = 0; c < `FU_NUM; c++) begin
                case ({grant_o[c], credit_return_i[c]})
                    2'b10:   credit_q[c] <= credit_q[c] - 1'b1;
                    2'b01:   credit_q[c] <= credit_q[c] + 1'b1;
                    default: credit_q[c] <= credit_q[c];
                endcase
            end
        end
    end

endmodule

// File: logic/rs_entry_array.sv
`timescale 1ns/1ps
`include "issue_defines.svh"

module rs_entry_array (
    input  logic                                     clock,
    input  logic                                     rst_n_i,
    input  logic                                     alloc_en_i,
    input  issue_pkg::rs_idx_t                       alloc_idx_i,
    input  issue_pkg::disp_packet_t                  disp_packet_i,
    input  issue_pkg::cdb_t                          cdb_i,
    input  logic [`RS_DEPTH-1:0]                     clear_mask_i,
    output issue_pkg::rs_entry_t [`RS_DEPTH-1:0]     entries_o,
    output logic [`RS_DEPTH-1:0]                     valid_mask_o,
    output logic [`RS_DEPTH-1:0]                     ready_mask_o
);

    logic [`RS_DEPTH-1:0]    valid_q;
    issue_pkg::disp_packet_t pkt_q [`RS_DEPTH];
    issue_pkg::disp_packet_t alloc_pkt;

    // incoming packet sees this cycle's broadcast too
    always_comb begin
        alloc_pkt = disp_packet_i;
        if (cdb_i.valid && disp_packet_i.src1_tag == cdb_i.tag) begin
            alloc_pkt.src1_ready = 1'b1;
        end
        if (cdb_i.valid && disp_packet_i.src2_tag == cdb_i.tag) begin
            alloc_pkt.src2_ready = 1'b1;
        end
    end

    // ====================
    // entry valid bits
    // ====================
    // alloc targets a free slot, clear a valid one, so no overlap
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < `RS_DEPTH; i++) begin
                if (alloc_en_i && alloc_idx_i == issue_pkg::rs_idx_t'(i)) begin
                    valid_q[i] <= 1'b1;
                end else if (clear_mask_i[i]) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    // ====================
    // payload and wakeup
    // ====================
    always_ff @(posedge clock) begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            if (alloc_en_i && alloc_idx_i == issue_pkg::rs_idx_t'(i)) begin
                pkt_q[i] <= alloc_pkt;
            end else if (cdb_i.valid && valid_q[i]) begin
                // tag match on a waiting source
                if (pkt_q[i].src1_tag == cdb_i.tag) begin
                    pkt_q[i].src1_ready <= 1'b1;
                end
                if (pkt_q[i].src2_tag == cdb_i.tag) begin
                    pkt_q[i].src2_ready <= 1'b1;
                end
            end
        end
    end

    // ready means valid with both sources in
    always_comb begin
        for (int i = 0; i < `RS_DEPTH; i++) begin
            entries_o[i].valid       = valid_q[i];
            entries_o[i].disp_packet = pkt_q[i];
            ready_mask_o[i] = valid_q[i] && pkt_q[i].src1_ready && pkt_q[i].src2_ready;
        end
    end

    assign valid_mask_o = valid_q;

endmodule

// File: logic/issue_pkg.sv
`include "issue_defines.svh"

package issue_pkg;

    typedef logic [`RS_IDX_W-1:0]  rs_idx_t;
    typedef logic [`TAG_W-1:0]     tag_t;
    typedef logic [`ROB_IDX_W-1:0] rob_idx_t;

    // one bit per unit class, indexed by fu_type_e
    typedef logic [`FU_NUM-1:0] fu_vec_t;

    // micro-op as it leaves decode and rename
    typedef struct packed {
        isa_pkg::inst_t    inst;
        logic [`XLEN-1:0]  pc;
        logic [`XLEN-1:0]  npc;
        isa_pkg::opa_sel_e opa_select;
        isa_pkg::opb_sel_e opb_select;
        isa_pkg::alu_func_e alu_func;
        isa_pkg::fu_type_e fu_type;
        rob_idx_t          rob_idx;
        tag_t              dest_tag;
        tag_t              src1_tag;
        logic              src1_ready;
        tag_t              src2_tag;
        logic              src2_ready;
    } disp_packet_t;

    typedef struct packed {
        logic         valid;
        disp_packet_t disp_packet;
    } rs_entry_t;

    // single tag broadcast
    typedef struct packed {
        logic valid;
        tag_t tag;
    } cdb_t;

    // what a unit port receives
    typedef struct packed {
        logic               valid;
        isa_pkg::alu_func_e opcode;
        logic [`XLEN-1:0]   src1_val;
        logic [`XLEN-1:0]   src2_val;
        logic [`XLEN-1:0]   imm;
        logic               src2_valid;
        rob_idx_t           rob_idx;
        tag_t               dest_tag;
        isa_pkg::fu_type_e  fu_type;
    } issue_packet_t;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

    // ====================
    // instruction formats
    // ====================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // branch offset bits are scattered
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

    // ====================
    // operand selects
    // ====================
    typedef enum logic [1:0] {
        OPA_IS_RS1  = 2'd0,
        OPA_IS_NPC  = 2'd1,
        OPA_IS_PC   = 2'd2,
        OPA_IS_ZERO = 2'd3
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2   = 3'd0,
        OPB_IS_I_IMM = 3'd1,
        OPB_IS_S_IMM = 3'd2,
        OPB_IS_B_IMM = 3'd3,
        OPB_IS_U_IMM = 3'd4,
        OPB_IS_J_IMM = 3'd5
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_MUL, ALU_MULH,
        ALU_MULHSU, ALU_MULHU
    } alu_func_e;

    // value doubles as index into per-class vectors
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_LOAD   = 2'd2,
        FU_BRANCH = 2'd3
    } fu_type_e;

    // ====================
    // immediates
    // ====================
    function automatic logic [31:0] imm_i(input inst_t inst);
        return {{20{inst.i.imm[11]}}, inst.i.imm};
    endfunction

    function automatic logic [31:0] imm_s(input inst_t inst);
        return {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    endfunction

    // bit 0 is always zero for branch and jump targets
    function automatic logic [31:0] imm_b(input inst_t inst);
        return {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    endfunction

    function automatic logic [31:0] imm_u(input inst_t inst);
        return {inst.u.imm, 12'b0};
    endfunction

    function automatic logic [31:0] imm_j(input inst_t inst);
        return {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    endfunction

endpackage

// File: include/issue_defines.svh
`ifndef ISSUE_DEFINES_SVH
`define ISSUE_DEFINES_SVH

// datapath width, RV32
`define XLEN 32

// reservation station
`define RS_DEPTH 8
`define RS_IDX_W $clog2(`RS_DEPTH)

// physical register tags
`define PHYS_REGS 64
`define TAG_W $clog2(`PHYS_REGS)

// reorder buffer index
`define ROB_DEPTH 32
`define ROB_IDX_W $clog2(`ROB_DEPTH)

// unit classes: alu, mul, load, branch
`define FU_NUM 4

// credits a unit class starts with
`define CREDIT_W 2
`define ALU_CREDITS 2
`define MUL_CREDITS 2
`define LOAD_CREDITS 2
`define BR_CREDITS 2

`endif
